//--- files.f
rtl/wakeupPkg.sv
rtl/wakeupControl.sv
rtl/wakeupLane.sv
rtl/flushRangeCheck.sv
rtl/wakeupPipeTop.sv
tests/wakeupClockGen.sv
tests/wakeupPipeTb.sv

//--- rtl/flushRangeCheck.sv
/*
 * Holds the active-list range of the last selective recovery and flags lane
 * outputs that fall inside it while that lane's window is open.
 * The range stays captured until the next selective recovery.
 */
`timescale 1ns/1ps

module flushRangeCheck (
    input  logic                clk,
    input  logic                arstN,
    input  wakeupPkg::recoveryT recovery,
    input  logic                windowOpen [wakeupPkg::numSlots],
    input  wakeupPkg::alIndexT  laneAlPtr [wakeupPkg::numSlots],
    output logic                kill [wakeupPkg::numSlots]
);
    import wakeupPkg::*;

    alIndexT flushHead;
    alIndexT flushTail;
    logic flushAll;

    // Capture on selective recovery only
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushHead <= '0;
            flushTail <= '0;
            flushAll <= 1'b0;
        end else if (recovery.toRecovery && recovery.fromRwStage) begin
            flushHead <= recovery.flushHead;
            flushTail <= recovery.flushTail;
            flushAll <= recovery.flushAll;
        end
    end

    always_comb begin
        for (int i = 0; i < numSlots; i++) begin
            kill[i] = windowOpen[i] &&
                      inFlushRange(flushAll, flushHead, flushTail, laneAlPtr[i]);
        end
    end

endmodule

//--- rtl/wakeupControl.sv
/*
 * Recovery decode and per-slot flush window counters.
 * Full recovery clears the lanes in the same cycle; selective recovery opens
 * a window per slot that lasts as long as that slot's lane latency.
 */
`timescale 1ns/1ps

module wakeupControl (
    input  logic                clk,
    input  logic                arstN,
    input  logic                stall,
    input  wakeupPkg::recoveryT recovery,
    output logic                clearLanes,
    output logic                windowOpen [wakeupPkg::numSlots],
    output logic                flushedOpExist
);
    import wakeupPkg::*;

    windowCountT windowCount [numSlots];
    logic selectiveRecovery;

    // Recovery from the RW stage is selective, anything else flushes every lane
    assign clearLanes = recovery.toRecovery && !recovery.fromRwStage;
    assign selectiveRecovery = recovery.toRecovery && recovery.fromRwStage;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numSlots; i++) begin
                windowCount[i] <= '0;
            end
        end else if (selectiveRecovery) begin
            for (int i = 0; i < numSlots; i++) begin
                windowCount[i] <= windowCountT'(slotLatency(i));
            end
        end else begin
            for (int i = 0; i < numSlots; i++) begin
                // The entry stage does not move under stall, so the first
                // step of the window waits for a free cycle
                if (windowCount[i] == windowCountT'(slotLatency(i))) begin
                    if (!stall) begin
                        windowCount[i] <= windowCount[i] - 1'b1;
                    end
                end else if (windowCount[i] != '0) begin
                    windowCount[i] <= windowCount[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        flushedOpExist = 1'b0;
        for (int i = 0; i < numSlots; i++) begin
            windowOpen[i] = (windowCount[i] != '0);
            flushedOpExist = flushedOpExist || windowOpen[i];
        end
    end

endmodule

//--- rtl/wakeupLane.sv
/*
 * One fixed-latency issue lane. Stage latency-1 is the entry stage, stage 0
 * the output stage. On stall only the entry stage holds; later stages keep
 * moving with a bubble behind the entry. With latency 1 the output stage is
 * the held entry stage, so outputs are suppressed for the whole stall.
 */
`timescale 1ns/1ps

module wakeupLane #(
    parameter int latency = 1
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  logic                  clearLanes,
    input  wakeupPkg::iqOneHotT   flushIqEntry,
    input  wakeupPkg::selectSlotT pick,
    input  logic                  kill,
    output wakeupPkg::alIndexT    outAlPtr,
    output wakeupPkg::wakeupSlotT wakeup,
    output wakeupPkg::releaseSlotT releaseEntry
);
    import wakeupPkg::*;

    // Stage that takes the bubble while the entry stage holds
    localparam int bubbleStage = (latency > 1) ? latency - 2 : 0;
    localparam logic outIsEntry = (latency == 1);

    selectSlotT stage [latency];
    selectSlotT entry;
    logic holdOut;

    // Drop picks whose issue-queue entry is flushed in the select cycle
    always_comb begin
        entry = pick;
        entry.valid = pick.valid && !flushIqEntry[pick.iqPtr];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < latency; s++) begin
                stage[s].valid <= 1'b0;
            end
        end else if (clearLanes) begin
            for (int s = 0; s < latency; s++) begin
                stage[s].valid <= 1'b0;
                stage[s].depVector <= '0;
            end
        end else if (!stall) begin
            for (int s = 1; s < latency; s++) begin
                stage[s-1] <= stage[s];
            end
            stage[latency-1] <= entry;
        end else if (latency > 1) begin
            // Entry stage keeps its pick; everything behind it drains
            for (int s = 1; s < latency - 1; s++) begin
                stage[s-1] <= stage[s];
            end
            stage[bubbleStage].valid <= 1'b0;
            stage[bubbleStage].depVector <= '0;
        end
    end

    // Held entry stage must not wake or release twice
    assign holdOut = outIsEntry && stall;

    always_comb begin
        wakeup.valid = stage[0].valid && !kill && !holdOut;
        wakeup.iqPtr = stage[0].iqPtr;
        wakeup.depVector = holdOut ? '0 : stage[0].depVector;

        // Release goes out even for killed ops, the entry is done either way
        releaseEntry.valid = stage[0].valid && !holdOut;
        releaseEntry.iqPtr = stage[0].iqPtr;

        outAlPtr = stage[0].alPtr;
    end

endmodule

//--- rtl/wakeupPipeTop.sv
/*
 * Wakeup pipeline register: integer slots first, memory slot last.
 * Picks leave their lane after the lane latency to wake consumers and release
 * issue-queue entries. Stall is a level from the scheduler, no handshake.
 */
`timescale 1ns/1ps

module wakeupPipeTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   stall,
    input  wakeupPkg::selectSlotT  select [wakeupPkg::numSlots],
    input  wakeupPkg::recoveryT    recovery,
    output wakeupPkg::wakeupSlotT  wakeup [wakeupPkg::numSlots],
    output wakeupPkg::releaseSlotT releaseEntry [wakeupPkg::numSlots],
    output logic                   flushedOpExist
);
    import wakeupPkg::*;

    logic clearLanes;
    logic windowOpen [numSlots];
    logic kill [numSlots];
    alIndexT laneAlPtr [numSlots];

    wakeupControl wakeupControl_inst (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .recovery       (recovery),
        .clearLanes     (clearLanes),
        .windowOpen     (windowOpen),
        .flushedOpExist (flushedOpExist)
    );

    flushRangeCheck flushRangeCheck_inst (
        .clk        (clk),
        .arstN      (arstN),
        .recovery   (recovery),
        .windowOpen (windowOpen),
        .laneAlPtr  (laneAlPtr),
        .kill       (kill)
    );

    // Integer lanes take intLatency, the last slot is the memory lane
    for (genvar i = 0; i < numSlots; i++) begin : gLane
        wakeupLane #(
            .latency (slotLatency(i))
        ) wakeupLane_inst (
            .clk          (clk),
            .arstN        (arstN),
            .stall        (stall),
            .clearLanes   (clearLanes),
            .flushIqEntry (recovery.flushIqEntry),
            .pick         (select[i]),
            .kill         (kill[i]),
            .outAlPtr     (laneAlPtr[i]),
            .wakeup       (wakeup[i]),
            .releaseEntry (releaseEntry[i])
        );
    end

endmodule

//--- rtl/wakeupPkg.sv
/*
 * Shared sizes, latencies and slot types for the wakeup pipeline.
 * Slots 0 .. intLanes-1 are integer lanes and the last slot is the memory lane.
 * Window counters are sized from maxLatency, so maxLatency must track the lanes.
 */
package wakeupPkg;

    // Issue queue and active list geometry
    localparam int iqEntries = 16;
    localparam int activeListEntries = 32;

    typedef logic [$clog2(iqEntries)-1:0] iqIndexT;
    typedef logic [iqEntries-1:0] iqOneHotT;
    typedef logic [$clog2(activeListEntries)-1:0] alIndexT;

    // Lane configuration
    localparam int intLanes = 2;
    localparam int intLatency = 1;
    localparam int memLatency = 3;
    localparam int numSlots = intLanes + 1;
    localparam int maxLatency = (memLatency > intLatency) ? memLatency : intLatency;

    typedef logic [$clog2(maxLatency+1)-1:0] windowCountT;

    // One pick from the select logic
    typedef struct packed {
        logic valid;
        iqIndexT iqPtr;
        iqOneHotT depVector;
        alIndexT alPtr;
    } selectSlotT;

    typedef struct packed {
        logic valid;
        iqIndexT iqPtr;
        iqOneHotT depVector;
    } wakeupSlotT;

    typedef struct packed {
        logic valid;
        iqIndexT iqPtr;
    } releaseSlotT;

    // Recovery command from the recovery manager
    typedef struct packed {
        logic toRecovery;
        logic fromRwStage;
        alIndexT flushHead;
        alIndexT flushTail;
        logic flushAll;
        iqOneHotT flushIqEntry;
    } recoveryT;

    // Latency of the lane behind a given slot
    function automatic int slotLatency(input int slot);
        return (slot < intLanes) ? intLatency : memLatency;
    endfunction

    // Circular range [head, tail), empty when head equals tail
    function automatic logic inFlushRange(input logic flushAll, input alIndexT head,
                                          input alIndexT tail, input alIndexT index);
        logic inRange;
        if (head < tail) begin
            inRange = (index >= head) && (index < tail);
        end else if (head > tail) begin
            inRange = (index >= head) || (index < tail);
        end else begin
            inRange = 1'b0;
        end
        return flushAll || inRange;
    endfunction

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build and run the wakeup pipeline testbench with Verilator.
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -f files.f --top-module wakeupPipeTb -Mdir "$buildDir" -o simv
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
status=$?
cat "$logFile"

if grep -q "FAIL: see errors above" "$logFile"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- tests/wakeupClockGen.sv
/*
 * Free-running testbench clock and an active-low reset.
 * Reset is held for resetCycles rising edges and released on a falling edge.
 */
`timescale 1ns/1ps

module wakeupClockGen #(
    parameter int periodNs = 100,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

    // Release between rising edges so no flop sees it change at its clock
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

//--- tests/wakeupPipeTb.sv
/*
 * Directed tests for the wakeup pipeline top. Inputs change on the rising
 * edge and outputs are checked on the falling edge of the same cycle.
 * Slots 0 and 1 are integer lanes, slot 2 is the memory lane.
 */
`timescale 1ns/1ps

module wakeupPipeTb;
    import wakeupPkg::*;

    localparam int clockPeriodNs = 100;
    localparam int resetCycles = 8;
    // Cycles spent by the five tests, in order
    localparam int testCycles = 4 + 7 + 8 + 9 + 15;
    localparam int marginCycles = 20;
    localparam selectSlotT noPick = '0;
    localparam recoveryT noRecovery = '0;

    logic clk;
    logic arstN;
    logic stall;
    selectSlotT select [numSlots];
    recoveryT recovery;
    wakeupSlotT wakeup [numSlots];
    releaseSlotT releaseEntry [numSlots];
    logic flushedOpExist;

    wakeupClockGen #(
        .periodNs    (clockPeriodNs),
        .resetCycles (resetCycles)
    ) wakeupClockGen_inst (
        .clk   (clk),
        .arstN (arstN)
    );

    wakeupPipeTop wakeupPipeTop_inst (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .select         (select),
        .recovery       (recovery),
        .wakeup         (wakeup),
        .releaseEntry   (releaseEntry),
        .flushedOpExist (flushedOpExist)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Payload only matters on a valid wakeup
    task automatic compareWakeup(input string testName, input wakeupSlotT expected,
                                 input wakeupSlotT actual);
        if (actual.valid !== expected.valid ||
            (expected.valid && (actual.iqPtr !== expected.iqPtr ||
                                actual.depVector !== expected.depVector))) begin
            reportFailure($sformatf("MISMATCH %s wakeup: expected %h actual %h",
                                    testName, expected, actual));
        end
    endtask

    task automatic compareRelease(input string testName, input releaseSlotT expected,
                                  input releaseSlotT actual);
        if (actual.valid !== expected.valid ||
            (expected.valid && actual.iqPtr !== expected.iqPtr)) begin
            reportFailure($sformatf("MISMATCH %s release: expected %h actual %h",
                                    testName, expected, actual));
        end
    endtask

    task automatic compareBit(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("MISMATCH %s: expected %b actual %b",
                                    testName, expected, actual));
        end
    endtask

    function automatic selectSlotT randomPick(input alIndexT alPtr);
        selectSlotT p;
        p.valid = 1'b1;
        p.iqPtr = iqIndexT'($urandom());
        p.depVector = iqOneHotT'($urandom());
        p.alPtr = alPtr;
        return p;
    endfunction

    // One clock cycle, driven at the rising edge and left at the falling edge
    task automatic stepCycle(input selectSlotT p0, input selectSlotT p1, input selectSlotT p2,
                             input recoveryT rec, input logic stallIn);
        @(posedge clk);
        select[0] <= p0;
        select[1] <= p1;
        select[2] <= p2;
        recovery <= rec;
        stall <= stallIn;
        @(negedge clk);
    endtask

    // Each slot shows the pick that should leave it now; kill clears wakeup only
    task automatic checkOutputs(input string testName, input selectSlotT e0,
                                input selectSlotT e1, input selectSlotT e2,
                                input logic [numSlots-1:0] killed, input logic status);
        selectSlotT expected [numSlots];
        wakeupSlotT expWake;
        releaseSlotT expRelease;
        expected[0] = e0;
        expected[1] = e1;
        expected[2] = e2;
        for (int i = 0; i < numSlots; i++) begin
            expWake.valid = expected[i].valid && !killed[i];
            expWake.iqPtr = expected[i].iqPtr;
            expWake.depVector = expected[i].depVector;
            expRelease.valid = expected[i].valid;
            expRelease.iqPtr = expected[i].iqPtr;
            compareWakeup($sformatf("%s slot %0d", testName, i), expWake, wakeup[i]);
            compareRelease($sformatf("%s slot %0d", testName, i), expRelease, releaseEntry[i]);
        end
        compareBit($sformatf("%s flushedOpExist", testName), status, flushedOpExist);
    endtask

    task automatic stepIdle();
        stepCycle(noPick, noPick, noPick, noRecovery, 1'b0);
    endtask

    task automatic idleCycle(input string testName);
        stepIdle();
        checkOutputs(testName, noPick, noPick, noPick, 3'b000, 1'b0);
    endtask

    task automatic testIntegerLatency();
        selectSlotT a;
        selectSlotT b;
        selectSlotT c;
        a = randomPick(5'd1);
        b = randomPick(5'd2);
        c = randomPick(5'd3);
        stepCycle(a, noPick, noPick, noRecovery, 1'b0);
        checkOutputs("integer cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(c, b, noPick, noRecovery, 1'b0);
        checkOutputs("integer cycle 1", a, noPick, noPick, 3'b000, 1'b0);
        stepIdle();
        checkOutputs("integer cycle 2", c, b, noPick, 3'b000, 1'b0);
        idleCycle("integer cycle 3");
    endtask

    // Three back-to-back memory picks are in flight together
    task automatic testMemoryLatency();
        selectSlotT picks [3];
        selectSlotT expected;
        for (int i = 0; i < 3; i++) begin
            picks[i] = randomPick(alIndexT'(8 + i));
        end
        for (int c = 0; c < 7; c++) begin
            expected = (c >= 3 && c < 6) ? picks[c % 3] : noPick;
            stepCycle(noPick, noPick, (c < 3) ? picks[c % 3] : noPick, noRecovery, 1'b0);
            checkOutputs($sformatf("memory cycle %0d", c), noPick, noPick, expected,
                         3'b000, 1'b0);
        end
    endtask

    task automatic testStall();
        selectSlotT memA;
        selectSlotT memB;
        selectSlotT intP;
        memA = randomPick(5'd12);
        memB = randomPick(5'd13);
        intP = randomPick(5'd14);
        stepCycle(noPick, noPick, memA, noRecovery, 1'b0);
        checkOutputs("stall cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(intP, noPick, memB, noRecovery, 1'b0);
        checkOutputs("stall cycle 1", noPick, noPick, noPick, 3'b000, 1'b0);
        // intP sits in the integer output stage but is held back
        stepCycle(noPick, noPick, noPick, noRecovery, 1'b1);
        checkOutputs("stall cycle 2", noPick, noPick, noPick, 3'b000, 1'b0);
        compareBit("stall cycle 2 depVector nonzero", 1'b0, |wakeup[0].depVector);
        // memA was already past the entry stage
        stepCycle(noPick, noPick, noPick, noRecovery, 1'b1);
        checkOutputs("stall cycle 3", noPick, noPick, memA, 3'b000, 1'b0);
        compareBit("stall cycle 3 depVector nonzero", 1'b0, |wakeup[0].depVector);
        stepIdle();
        checkOutputs("stall cycle 4", intP, noPick, noPick, 3'b000, 1'b0);
        idleCycle("stall cycle 5");
        // memB waited in the entry stage for both stall cycles
        stepIdle();
        checkOutputs("stall cycle 6", noPick, noPick, memB, 3'b000, 1'b0);
        idleCycle("stall cycle 7");
    endtask

    task automatic testFilterAndFullRecovery();
        selectSlotT flushedInt;
        selectSlotT keptInt;
        selectSlotT flushedMem;
        selectSlotT memA;
        selectSlotT intR;
        recoveryT rec;
        flushedInt = randomPick(5'd2);
        keptInt = randomPick(5'd3);
        keptInt.iqPtr = flushedInt.iqPtr + 4'd1;
        flushedMem = randomPick(5'd4);
        flushedMem.iqPtr = flushedInt.iqPtr;
        memA = randomPick(5'd5);
        intR = randomPick(5'd7);
        rec = noRecovery;
        rec.flushIqEntry = iqOneHotT'(1) << flushedInt.iqPtr;
        stepCycle(flushedInt, keptInt, flushedMem, rec, 1'b0);
        checkOutputs("filter cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        stepIdle();
        checkOutputs("filter cycle 1", noPick, keptInt, noPick, 3'b000, 1'b0);
        idleCycle("filter cycle 2");
        idleCycle("filter cycle 3");
        rec = noRecovery;
        rec.toRecovery = 1'b1;
        stepCycle(noPick, noPick, memA, noRecovery, 1'b0);
        checkOutputs("full recovery cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        // Picks made in the recovery cycle are dropped along with memA
        stepCycle(randomPick(5'd8), randomPick(5'd9), randomPick(5'd6), rec, 1'b0);
        checkOutputs("full recovery cycle 1", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(intR, noPick, noPick, noRecovery, 1'b0);
        checkOutputs("full recovery cycle 2", noPick, noPick, noPick, 3'b000, 1'b0);
        stepIdle();
        checkOutputs("full recovery cycle 3", intR, noPick, noPick, 3'b000, 1'b0);
        idleCycle("full recovery cycle 4");
    endtask

    task automatic testSelectiveRecovery();
        selectSlotT mem [4];
        selectSlotT int0;
        selectSlotT int1;
        selectSlotT late;
        recoveryT rec;
        // Range wraps around the active list, 28 to 31 and 0 to 2
        mem[0] = randomPick(5'd30);
        mem[1] = randomPick(5'd10);
        mem[2] = randomPick(5'd1);
        mem[3] = randomPick(5'd30);
        int0 = randomPick(5'd28);
        int1 = randomPick(5'd3);
        rec = noRecovery;
        rec.toRecovery = 1'b1;
        rec.fromRwStage = 1'b1;
        rec.flushHead = 5'd28;
        rec.flushTail = 5'd3;
        stepCycle(noPick, noPick, mem[0], noRecovery, 1'b0);
        checkOutputs("selective cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(noPick, noPick, mem[1], noRecovery, 1'b0);
        checkOutputs("selective cycle 1", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(int0, int1, mem[2], rec, 1'b0);
        checkOutputs("selective cycle 2", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(noPick, noPick, mem[3], noRecovery, 1'b0);
        checkOutputs("selective cycle 3", int0, int1, mem[0], 3'b101, 1'b1);
        stepIdle();
        checkOutputs("selective cycle 4", noPick, noPick, mem[1], 3'b000, 1'b1);
        stepIdle();
        checkOutputs("selective cycle 5", noPick, noPick, mem[2], 3'b100, 1'b1);
        // Window has closed, so an in-range alPtr wakes up again
        stepIdle();
        checkOutputs("selective cycle 6", noPick, noPick, mem[3], 3'b000, 1'b0);
        idleCycle("selective cycle 7");
        // flushAll kills every in-flight wakeup whatever its alPtr
        rec.flushAll = 1'b1;
        rec.flushHead = 5'd0;
        rec.flushTail = 5'd0;
        for (int i = 0; i < 3; i++) begin
            mem[i] = randomPick(alIndexT'(4 * i + 6));
        end
        int0 = randomPick(5'd11);
        int1 = randomPick(5'd13);
        late = randomPick(5'd15);
        stepCycle(noPick, noPick, mem[0], noRecovery, 1'b0);
        checkOutputs("flushAll cycle 0", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(noPick, noPick, mem[1], noRecovery, 1'b0);
        checkOutputs("flushAll cycle 1", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(int0, int1, mem[2], rec, 1'b0);
        checkOutputs("flushAll cycle 2", noPick, noPick, noPick, 3'b000, 1'b0);
        stepCycle(late, noPick, noPick, noRecovery, 1'b0);
        checkOutputs("flushAll cycle 3", int0, int1, mem[0], 3'b111, 1'b1);
        stepIdle();
        checkOutputs("flushAll cycle 4", late, noPick, mem[1], 3'b100, 1'b1);
        stepIdle();
        checkOutputs("flushAll cycle 5", noPick, noPick, mem[2], 3'b100, 1'b1);
        idleCycle("flushAll cycle 6");
    endtask

    initial begin
        void'($urandom(85167));
        stall = 1'b0;
        recovery = noRecovery;
        for (int i = 0; i < numSlots; i++) begin
            select[i] = noPick;
        end
        wait (arstN === 1'b1);
        checkOutputs("after reset", noPick, noPick, noPick, 3'b000, 1'b0);
        testIntegerLatency();
        testMemoryLatency();
        testStall();
        testFilterAndFullRecovery();
        testSelectiveRecovery();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #((resetCycles + testCycles + marginCycles) * clockPeriodNs);
        reportFailure("Timeout: the tests did not finish within their cycle budget");
    end

endmodule
